/* flist.f */
+incdir+hdl
hdl/imuldiv_pkg.sv
hdl/imuldiv_iter_if.sv
hdl/imuldiv_iter_ctrl.sv
hdl/imuldiv_mul_dpath.sv
hdl/imuldiv_div_dpath.sv
hdl/imuldiv_dispatch.sv
hdl/imuldiv_unit.sv
tb/imuldiv_assert.sv
tb/tb_imuldiv.sv

/* hdl/imuldiv_consts.svh */
/* widths and codes shared by the multiply/divide unit
   the order queue depth must be a power of two */
`ifndef IMULDIV_CONSTS_SVH
`define IMULDIV_CONSTS_SVH

`default_nettype none

// operand width and step counter width
`define IMULDIV_XLEN 32
`define IMULDIV_CNT_W 5

// function codes carried on req_fn
`define IMULDIV_FN_MUL 1'b0
`define IMULDIV_FN_DIV 1'b1

// one queue slot per unit
`define IMULDIV_Q_DEPTH 2

`default_nettype wire

`endif

/* hdl/imuldiv_dispatch.sv */
/* steers requests by req_fn and returns responses in request order
   queue holds function codes only, one slot per unit */
`timescale 1ns/1ps

`include "imuldiv_consts.svh"

`default_nettype none

module imuldiv_dispatch
  import imuldiv_pkg::*;
(
  input  logic   clk,
  input  logic   reset,

  input  fn_t    req_fn,
  input  logic   req_val,
  output logic   req_rdy,
  output logic   mul_req_val,
  output logic   div_req_val,
  input  logic   mul_req_rdy,
  input  logic   div_req_rdy,

  input  logic   mul_resp_val,
  input  logic   div_resp_val,
  input  dword_t mul_result,
  input  dword_t div_result,
  output logic   resp_val,
  output dword_t resp_result,
  input  logic   resp_rdy,
  output logic   mul_resp_rdy,
  output logic   div_resp_rdy
);

  localparam int unsigned PTR_W = $clog2(`IMULDIV_Q_DEPTH);
  localparam int unsigned CNT_W = $clog2(`IMULDIV_Q_DEPTH + 1);

  fn_t              fn_q [`IMULDIV_Q_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic full;
  logic empty;
  logic is_mul;
  logic head_mul;
  logic push;
  logic pop;

  assign full  = (count == CNT_W'(`IMULDIV_Q_DEPTH));
  assign empty = (count == '0);

  // ----------------------------------------------------------------------
  // request side
  // ----------------------------------------------------------------------

  assign is_mul      = (req_fn == `IMULDIV_FN_MUL);
  assign req_rdy     = !full && (is_mul ? mul_req_rdy : div_req_rdy);
  assign mul_req_val = req_val && is_mul && !full;
  assign div_req_val = req_val && !is_mul && !full;
  assign push        = req_val && req_rdy;

  // ----------------------------------------------------------------------
  // response side, only the head unit may answer
  // ----------------------------------------------------------------------

  assign head_mul     = (fn_q[rd_ptr] == `IMULDIV_FN_MUL);
  assign resp_val     = !empty && (head_mul ? mul_resp_val : div_resp_val);
  assign resp_result  = head_mul ? mul_result : div_result;
  assign mul_resp_rdy = !empty && head_mul && resp_rdy;
  assign div_resp_rdy = !empty && !head_mul && resp_rdy;
  assign pop          = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (push) begin
      fn_q[wr_ptr] <= req_fn;
    end
  end

  // pointers wrap since depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/imuldiv_div_dpath.sv */
/* signed restoring divide; result is {remainder, quotient}
   zero divisor gives an undefined result, MIN / -1 wraps */
`timescale 1ns/1ps

`include "imuldiv_consts.svh"

`default_nettype none

module imuldiv_div_dpath
  import imuldiv_pkg::*;
(
  input  logic   clk,
  input  logic   reset,

  input  word_t  a,
  input  word_t  b,
  output dword_t result,

  imuldiv_iter_if.dpath iter
);

  word_t  a_mag;
  word_t  b_mag;
  word_t  divisor;
  word_t  quo;
  word_t  rem;
  word_t  quo_out;
  word_t  rem_out;
  dword_t rq;
  dword_t rq_shift;
  logic [`IMULDIV_XLEN:0] diff;
  cnt_t   count;
  logic   sign_a;
  logic   sign_b;

  assign a_mag = a[`IMULDIV_XLEN-1] ? (~a + 1'b1) : a;
  assign b_mag = b[`IMULDIV_XLEN-1] ? (~b + 1'b1) : b;

  // ----------------------------------------------------------------------
  // trial subtract
  // ----------------------------------------------------------------------

  // remainder in the upper half, dividend bits shift out of the lower half
  assign rq_shift = rq << 1;
  // extra bit catches a negative trial remainder
  assign diff = {1'b0, rq_shift[2*`IMULDIV_XLEN-1:`IMULDIV_XLEN]} - {1'b0, divisor};

  always_ff @(posedge clk) begin
    if (iter.load) begin
      sign_a  <= a[`IMULDIV_XLEN-1];
      sign_b  <= b[`IMULDIV_XLEN-1];
      divisor <= b_mag;
      rq      <= dword_t'(a_mag);
    end else if (iter.step) begin
      if (iter.take) begin
        // keep the difference and set the new quotient bit
        rq <= {diff[`IMULDIV_XLEN-1:0], rq_shift[`IMULDIV_XLEN-1:1], 1'b1};
      end else begin
        rq <= rq_shift;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (iter.load) begin
      count <= cnt_t'(`IMULDIV_XLEN - 1);
    end else if (iter.step) begin
      count <= count - 1'b1;
    end
  end

  assign iter.cond = ~diff[`IMULDIV_XLEN];
  assign iter.last = (count == '0);

  // ----------------------------------------------------------------------
  // sign correction
  // ----------------------------------------------------------------------

  assign quo = rq[`IMULDIV_XLEN-1:0];
  assign rem = rq[2*`IMULDIV_XLEN-1:`IMULDIV_XLEN];

  // quotient truncates toward zero
  assign quo_out = (sign_a ^ sign_b) ? (~quo + 1'b1) : quo;
  // remainder follows the dividend
  assign rem_out = sign_a ? (~rem + 1'b1) : rem;

  assign result = {rem_out, quo_out};

endmodule

`default_nettype wire

/* hdl/imuldiv_iter_ctrl.sv */
/* one operation in flight; req_rdy only while IDLE
   result must stay valid in the datapath for all of DONE */
`timescale 1ns/1ps

`default_nettype none

module imuldiv_iter_ctrl
  import imuldiv_pkg::*;
(
  input  logic clk,
  input  logic reset,

  input  logic req_val,
  output logic req_rdy,

  output logic resp_val,
  input  logic resp_rdy,

  imuldiv_iter_if.ctrl iter
);

  iter_state_e state;
  iter_state_e state_next;

  logic accept;
  logic respond;

  // handshake strobes straight from the state
  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);

  assign accept  = req_val && req_rdy;
  assign respond = resp_val && resp_rdy;

  // ----------------------------------------------------------------------
  // datapath strobes
  // ----------------------------------------------------------------------

  // operands are only stable on the accepting edge
  assign iter.load = accept;
  assign iter.step = (state == CALC);
  // add or subtract kept only when the datapath says so
  assign iter.take = iter.step && iter.cond;

  // ----------------------------------------------------------------------
  // next state
  // ----------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (accept) begin
          state_next = CALC;
        end
      end
      CALC: begin
        // counter hit zero on this step
        if (iter.last) begin
          state_next = DONE;
        end
      end
      DONE: begin
        if (respond) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

endmodule

`default_nettype wire

/* hdl/imuldiv_iter_if.sv */
/* strobes between a control FSM and one iterative datapath
   cond and last are combinational from datapath registers */
`timescale 1ns/1ps

`default_nettype none

interface imuldiv_iter_if;

  // control to datapath
  logic load;
  logic step;
  logic take;

  // datapath to control
  logic cond;
  logic last;

  modport ctrl (
    output load, step, take,
    input  cond, last
  );

  modport dpath (
    input  load, step, take,
    output cond, last
  );

endinterface

`default_nettype wire

/* hdl/imuldiv_mul_dpath.sv */
/* signed shift-add multiply over magnitudes, sign fixed at the output
   always 32 steps, no early exit */
`timescale 1ns/1ps

`include "imuldiv_consts.svh"

`default_nettype none

module imuldiv_mul_dpath
  import imuldiv_pkg::*;
(
  input  logic   clk,
  input  logic   reset,

  input  word_t  a,
  input  word_t  b,
  output dword_t result,

  imuldiv_iter_if.dpath iter
);

  word_t  a_mag;
  word_t  b_mag;
  word_t  mplier;
  dword_t mcand;
  dword_t acc;
  dword_t acc_sum;
  cnt_t   count;
  logic   sign_a;
  logic   sign_b;

  // strip the signs, most negative value maps to 2^31 unsigned
  assign a_mag = a[`IMULDIV_XLEN-1] ? (~a + 1'b1) : a;
  assign b_mag = b[`IMULDIV_XLEN-1] ? (~b + 1'b1) : b;

  assign acc_sum = acc + mcand;

  // ----------------------------------------------------------------------
  // operand and partial product registers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (iter.load) begin
      sign_a <= a[`IMULDIV_XLEN-1];
      sign_b <= b[`IMULDIV_XLEN-1];
      mcand  <= dword_t'(a_mag);
      mplier <= b_mag;
      acc    <= '0;
    end else if (iter.step) begin
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
      // multiplier bit was set
      if (iter.take) begin
        acc <= acc_sum;
      end
    end
  end

  // step counter, 31 down to 0
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (iter.load) begin
      count <= cnt_t'(`IMULDIV_XLEN - 1);
    end else if (iter.step) begin
      count <= count - 1'b1;
    end
  end

  assign iter.cond = mplier[0];
  assign iter.last = (count == '0);

  // negative product when exactly one operand was negative
  assign result = (sign_a ^ sign_b) ? (~acc + 1'b1) : acc;

endmodule

`default_nettype wire

/* hdl/imuldiv_pkg.sv */
/* types for the iterative multiply/divide unit
   widths come from the constants header */
`include "imuldiv_consts.svh"

`default_nettype none

package imuldiv_pkg;

  // operand, quotient or remainder
  typedef logic [`IMULDIV_XLEN-1:0] word_t;

  // full result, also the partial product
  typedef logic [2*`IMULDIV_XLEN-1:0] dword_t;

  // counts the 32 shift steps down to zero
  typedef logic [`IMULDIV_CNT_W-1:0] cnt_t;

  // multiply or divide select
  typedef logic fn_t;

  // sequencing of one iterative operation
  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } iter_state_e;

endpackage

`default_nettype wire

/* hdl/imuldiv_unit.sv */
/* signed 32-bit multiply and divide, one of each in flight
   response 33 cycles after acceptance when at the queue head
   divide result is {remainder, quotient}; zero divisor undefined */
`timescale 1ns/1ps

`default_nettype none

module imuldiv_unit
  import imuldiv_pkg::*;
(
  input  logic   clk,
  input  logic   reset,

  input  word_t  req_a,
  input  word_t  req_b,
  input  fn_t    req_fn,
  input  logic   req_val,
  output logic   req_rdy,

  output dword_t resp_result,
  output logic   resp_val,
  input  logic   resp_rdy
);

  // per-unit handshake between dispatcher and control
  logic   mul_req_val;
  logic   mul_req_rdy;
  logic   mul_resp_val;
  logic   mul_resp_rdy;
  logic   div_req_val;
  logic   div_req_rdy;
  logic   div_resp_val;
  logic   div_resp_rdy;
  dword_t mul_result;
  dword_t div_result;

  imuldiv_iter_if mul_iter ();
  imuldiv_iter_if div_iter ();

  imuldiv_dispatch i_dispatch (
    .clk          (clk),
    .reset        (reset),
    .req_fn       (req_fn),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .mul_req_val  (mul_req_val),
    .div_req_val  (div_req_val),
    .mul_req_rdy  (mul_req_rdy),
    .div_req_rdy  (div_req_rdy),
    .mul_resp_val (mul_resp_val),
    .div_resp_val (div_resp_val),
    .mul_result   (mul_result),
    .div_result   (div_result),
    .resp_val     (resp_val),
    .resp_result  (resp_result),
    .resp_rdy     (resp_rdy),
    .mul_resp_rdy (mul_resp_rdy),
    .div_resp_rdy (div_resp_rdy)
  );

  // ----------------------------------------------------------------------
  // multiply path
  // ----------------------------------------------------------------------

  imuldiv_iter_ctrl i_mul_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy),
    .iter     (mul_iter.ctrl)
  );

  imuldiv_mul_dpath i_mul_dpath (
    .clk    (clk),
    .reset  (reset),
    .a      (req_a),
    .b      (req_b),
    .result (mul_result),
    .iter   (mul_iter.dpath)
  );

  // ----------------------------------------------------------------------
  // divide path
  // ----------------------------------------------------------------------

  imuldiv_iter_ctrl i_div_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy),
    .iter     (div_iter.ctrl)
  );

  imuldiv_div_dpath i_div_dpath (
    .clk    (clk),
    .reset  (reset),
    .a      (req_a),
    .b      (req_b),
    .result (div_result),
    .iter   (div_iter.dpath)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it
# the exit status of the run is the pass or fail result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_imuldiv \
  -f flist.f \
  -o tb_imuldiv \
  && ./obj_dir/tb_imuldiv \
  || exit 1

/* tb/imuldiv_assert.sv */
/* handshake and order queue checks bound into imuldiv_unit
   reaches into the dispatcher and both control FSMs by instance name */
`timescale 1ns/1ps

`include "imuldiv_consts.svh"

`default_nettype none

module imuldiv_assert
  import imuldiv_pkg::*;
(
  input logic        clk,
  input logic        reset,
  input logic [$clog2(`IMULDIV_Q_DEPTH + 1)-1:0] q_count,
  input iter_state_e mul_state,
  input logic        mul_resp_val,
  input logic        mul_resp_rdy,
  input dword_t      mul_result,
  input iter_state_e div_state,
  input logic        div_resp_val,
  input logic        div_resp_rdy,
  input dword_t      div_result
);

  // ----------------------------------------------------------------------
  // response side
  // ----------------------------------------------------------------------

  // a finished unit always owns an entry in the order queue
  assert property (@(posedge clk) disable iff (reset)
    (mul_resp_val || div_resp_val) |-> (q_count != '0))
    else $error("unit response while the order queue is empty");

  // DONE is left only through a transfer, result held meanwhile
  assert property (@(posedge clk) disable iff (reset)
    (mul_resp_val && !mul_resp_rdy) |=> (mul_resp_val && $stable(mul_result)))
    else $error("multiply response dropped or changed without a transfer");

  assert property (@(posedge clk) disable iff (reset)
    (div_resp_val && !div_resp_rdy) |=> (div_resp_val && $stable(div_result)))
    else $error("divide response dropped or changed without a transfer");

  // ----------------------------------------------------------------------
  // order queue
  // ----------------------------------------------------------------------

  // one entry per busy unit, so never more than one slot each
  assert property (@(posedge clk) disable iff (reset)
    int'(q_count) == int'(mul_state != IDLE) + int'(div_state != IDLE))
    else $error("order queue count does not match the busy units");

endmodule

bind imuldiv_unit imuldiv_assert i_assert (
  .clk          (clk),
  .reset        (reset),
  .q_count      (i_dispatch.count),
  .mul_state    (i_mul_ctrl.state),
  .mul_resp_val (mul_resp_val),
  .mul_resp_rdy (mul_resp_rdy),
  .mul_result   (mul_result),
  .div_state    (i_div_ctrl.state),
  .div_resp_val (div_resp_val),
  .div_resp_rdy (div_resp_rdy),
  .div_result   (div_result)
);

`default_nettype wire

/* tb/tb_imuldiv.sv */
/* random multiply/divide traffic checked against a signed model
   zero divisors are never sent; stops at the first mismatch */
`timescale 1ns/1ps

`include "imuldiv_consts.svh"

`default_nettype none

module tb_imuldiv
  import imuldiv_pkg::*;
();

  localparam int N_RANDOM      = 300;
  localparam int LATENCY       = 33;
  localparam int REQ_TIMEOUT   = 400;
  localparam int DRAIN_TIMEOUT = 2000;

  logic   clk;
  logic   reset;
  word_t  req_a;
  word_t  req_b;
  fn_t    req_fn;
  logic   req_val;
  logic   req_rdy;
  dword_t resp_result;
  logic   resp_val;
  logic   resp_rdy;

  integer seed;
  logic   rdy_random;
  // expected results in request order
  dword_t exp_q[$];
  int     acc_count;
  int     resp_count;
  // last cycle ended with a stalled response
  logic   held;
  dword_t held_result;

  imuldiv_unit i_dut (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_fn      (req_fn),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  // signed product, or {remainder, quotient} with truncation toward zero
  function automatic dword_t expected_result(input word_t a, input word_t b, input fn_t fn);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] quo;
    logic signed [63:0] rem;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    if (fn == `IMULDIV_FN_MUL) begin
      return sa * sb;
    end
    // MIN / -1 is exact in 64 bits and wraps when cut to 32
    quo = sa / sb;
    rem = sa % sb;
    return {rem[31:0], quo[31:0]};
  endfunction

  // one rising edge with resp_rdy redrawn under random back-pressure
  task automatic tick();
    @(posedge clk);
    if (rdy_random) begin
      resp_rdy <= (($random(seed) & 3) != 0);
    end
  endtask

  // edge values mixed with plain random words
  task automatic pick_operand(output word_t v);
    int sel;
    sel = $random(seed) & 7;
    case (sel)
      0: v = '0;
      1: v = '1;
      2: v = 32'h8000_0000;
      3: v = 32'h7fff_ffff;
      default: v = $random(seed);
    endcase
  endtask

  // holds the request until accepted
  // waited counts the refused edges
  task automatic send_req(input word_t a, input word_t b, input fn_t fn, output int waited);
    req_a   <= a;
    req_b   <= b;
    req_fn  <= fn;
    req_val <= 1'b1;
    waited = 0;
    tick();
    while (!req_rdy) begin
      if (waited >= REQ_TIMEOUT) begin
        abort_run($sformatf("Timeout at %0d ns: request was never accepted", $time));
      end
      waited++;
      tick();
    end
    req_val <= 1'b0;
  endtask

  // unit still busy so every edge must refuse
  task automatic hold_refused(input word_t a, input word_t b, input fn_t fn, input int cycles);
    req_a   <= a;
    req_b   <= b;
    req_fn  <= fn;
    req_val <= 1'b1;
    repeat (cycles) begin
      tick();
      assert (!req_rdy)
        else abort_run($sformatf("Error at %0d ns: request accepted by a busy unit", $time));
    end
  endtask

  // waits until every accepted request has been answered
  task automatic wait_drained();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (resp_count != acc_count) begin
      if (cycles >= DRAIN_TIMEOUT) begin
        abort_run($sformatf("Timeout at %0d ns: responses still outstanding", $time));
      end
      cycles++;
      tick();
      @(negedge clk);
    end
    tick();
  endtask

  // ----------------------------------------------------------------------
  // scoreboard
  // ----------------------------------------------------------------------

  always @(posedge clk) begin
    if (!reset) begin
      // a stalled response keeps its value
      if (held) begin
        assert (resp_val && resp_result == held_result)
          else abort_run($sformatf("Error at %0d ns: stalled response changed to %h",
                                   $time, resp_result));
      end
      if (resp_val && resp_rdy) begin
        assert (exp_q.size() != 0)
          else abort_run($sformatf("Error at %0d ns: response with no request pending", $time));
        assert (resp_result == exp_q[0])
          else abort_run($sformatf("Error at %0d ns: result %h, expected %h",
                                   $time, resp_result, exp_q[0]));
        void'(exp_q.pop_front());
        resp_count++;
      end
      if (req_val && req_rdy) begin
        exp_q.push_back(expected_result(req_a, req_b, req_fn));
        acc_count++;
      end
      held = resp_val && !resp_rdy;
      held_result = resp_result;
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------

  initial begin
    int    waited;
    int    n;
    word_t a;
    word_t b;
    fn_t   fn;
    seed = 69;
    rdy_random = 1'b0;
    held = 1'b0;
    held_result = '0;
    acc_count = 0;
    resp_count = 0;
    req_a = '0;
    req_b = '0;
    req_fn = `IMULDIV_FN_MUL;
    req_val = 1'b0;
    resp_rdy = 1'b1;
    reset = 1'b1;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    tick();
    assert (req_rdy === 1'b1 && resp_val === 1'b0)
      else abort_run($sformatf("Error at %0d ns: wrong handshake state after reset", $time));

    // idle unit answers on the 33rd edge after acceptance
    send_req(32'hffff_fff9, 32'd12345, `IMULDIV_FN_MUL, waited);
    n = 0;
    do begin
      tick();
      n++;
    end while (!resp_val && n < 2 * LATENCY);
    assert (n == LATENCY)
      else abort_run($sformatf("Error at %0d ns: response after %0d cycles", $time, n));
    wait_drained();

    // sign rules and the wrapping MIN / -1 case
    send_req(32'h8000_0000, 32'hffff_ffff, `IMULDIV_FN_DIV, waited);
    send_req(32'h8000_0000, 32'h8000_0000, `IMULDIV_FN_MUL, waited);
    send_req(32'hffff_ff9c, 32'd7, `IMULDIV_FN_DIV, waited);
    send_req(32'd100, 32'hffff_fff9, `IMULDIV_FN_DIV, waited);
    wait_drained();

    // both units in flight in either order
    send_req(32'd1234567, 32'hfedc_ba98, `IMULDIV_FN_MUL, waited);
    send_req(32'hffff_0000, 32'd3, `IMULDIV_FN_DIV, waited);
    assert (waited == 0)
      else abort_run($sformatf("Error at %0d ns: divide refused behind multiply", $time));
    wait_drained();
    send_req(32'd99999, 32'hffff_fffd, `IMULDIV_FN_DIV, waited);
    send_req(32'h7fff_ffff, 32'h7fff_ffff, `IMULDIV_FN_MUL, waited);
    assert (waited == 0)
      else abort_run($sformatf("Error at %0d ns: multiply refused behind divide", $time));
    wait_drained();

    // back-pressure holds the response and blocks the same unit
    resp_rdy <= 1'b0;
    send_req(32'd3, 32'hffff_fffe, `IMULDIV_FN_MUL, waited);
    hold_refused(32'd5, 32'd6, `IMULDIV_FN_MUL, 2 * LATENCY);
    resp_rdy <= 1'b1;
    send_req(32'd5, 32'd6, `IMULDIV_FN_MUL, waited);
    wait_drained();

    // random traffic under random back-pressure
    rdy_random = 1'b1;
    repeat (N_RANDOM) begin
      fn = fn_t'($random(seed) & 1);
      pick_operand(a);
      pick_operand(b);
      if (fn == `IMULDIV_FN_DIV && b == '0) begin
        b = 32'd1;
      end
      send_req(a, b, fn, waited);
    end
    wait_drained();
    rdy_random = 1'b0;

    // nothing left to answer once every request has its response
    assert (!resp_val)
      else abort_run($sformatf("Error at %0d ns: extra response after the last request",
                               $time));
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire
